// ==== hw/rom_bus_pkg.sv ====
package rom_bus_pkg;

    // one word as returned by the external rom port
    typedef logic [31:0] word_t;

    // data seen by an 8-bit cpu
    typedef logic [7:0] byte_t;

    // data seen by a 16-bit cpu
    typedef logic [15:0] half_t;

    // byte lane inside a word, taken from the low byte-address bits
    typedef logic [1:0] lane_t;

endpackage

// ==== hw/rom_arb_pkg.sv ====
package rom_arb_pkg;

    // arbiter fsm
    typedef enum logic {
        ARB_IDLE = 1'b0,    // nothing outstanding
        ARB_WAIT = 1'b1     // read issued, waiting for ack
    } arb_state_t;

    // which slot owns the memory port
    typedef logic slot_id_t;

    localparam slot_id_t SLOT_0 = 1'b0;    // 8-bit cpu, top priority
    localparam slot_id_t SLOT_1 = 1'b1;    // 16-bit cpu

endpackage

// ==== hw/rom_slot.sv ====
`timescale 1ns/10ps

module rom_slot #(
    parameter int AW        = 20,   // cpu byte address width
    parameter int DW        = 8,    // cpu data width, 8/16/32
    parameter bit INVERT_A0 = 1'b0  // byte swap inside a halfword
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [AW-1:0]      addr,       // cpu byte address
    input  logic               addr_ok,    // addr valid, held by the cpu
    input  rom_bus_pkg::word_t fill_data,  // word coming back from memory
    input  logic               fill_ok,    // shared ack, one cycle
    input  logic               fill_sel,   // high while this slot is granted
    output logic               req,        // miss level towards the arbiter
    output logic [AW-1:0]      addr_req,   // word aligned byte address
    output logic               data_ok,    // registered strobe
    output logic [DW-1:0]      dout
);

    localparam int TW = AW - 2;    // tag = word address

    logic [TW-1:0]       tag0;
    logic [TW-1:0]       tag1;
    rom_bus_pkg::word_t  word0;
    rom_bus_pkg::word_t  word1;
    logic                init;      // cache holds nothing yet
    logic                victim;    // entry replaced by the next fill
    logic                hit0;
    logic                hit1;
    logic                fill;
    rom_bus_pkg::lane_t  lane;
    rom_bus_pkg::word_t  data_mux;

    // address alignment and tag compare
    assign addr_req = {addr[AW-1:2], 2'b00};
    assign hit0     = !init && (addr[AW-1:2] == tag0);
    assign hit1     = !init && (addr[AW-1:2] == tag1);

    // an empty cache never hits, so the first valid address always misses
    assign req  = addr_ok && !(hit0 || hit1);
    assign fill = fill_sel && fill_ok;    // word for us on this edge

    // control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            init    <= 1'b1;
            victim  <= 1'b0;
            data_ok <= 1'b0;
        end else begin
            data_ok <= fill || (addr_ok && (hit0 || hit1));
            if (fill) begin
                init <= 1'b0;
                if (!init) begin
                    victim <= ~victim;    // alternate 0,1,0,...
                end
            end
        end
    end

    // cache storage
    // first fill after reset writes both entries so neither holds junk
    always_ff @(posedge clk) begin
        if (fill) begin
            if (init || !victim) begin
                tag0  <= addr_req[AW-1:2];
                word0 <= fill_data;
            end
            if (init || victim) begin
                tag1  <= addr_req[AW-1:2];
                word1 <= fill_data;
            end
        end
    end

    // fresh word bypasses the cache in the fill cycle
    always_comb begin
        if (fill) begin
            data_mux = fill_data;
        end else if (hit0) begin
            data_mux = word0;
        end else begin
            data_mux = word1;
        end
    end

    // lane select, A0 swap only makes sense for byte wide cpus
    always_comb begin
        lane[1] = addr[1];
        if (INVERT_A0 && DW == 8) begin
            lane[0] = ~addr[0];
        end else begin
            lane[0] = addr[0];
        end
    end

    generate
        if (DW == 8) begin : g_byte
            always_comb begin
                case (lane)
                    2'd0:    dout = data_mux[7:0];
                    2'd1:    dout = data_mux[15:8];
                    2'd2:    dout = data_mux[23:16];
                    default: dout = data_mux[31:24];
                endcase
            end
        end else if (DW == 16) begin : g_half
            // byte address, so bit 1 picks the half
            assign dout = lane[1] ? data_mux[31:16] : data_mux[15:0];
        end else if (DW == 32) begin : g_word
            assign dout = data_mux;
        end else begin : g_bad
            $error("rom_slot: DW must be 8, 16 or 32");
        end
    endgenerate

endmodule

// ==== hw/rom_arbiter.sv ====
`timescale 1ns/10ps

module rom_arbiter #(
    parameter int AW = 20    // cpu byte address width
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               req0,        // slot 0 miss
    input  logic               req1,        // slot 1 miss
    input  logic [AW-1:0]      addr_req0,
    input  logic [AW-1:0]      addr_req1,
    input  rom_bus_pkg::word_t mem_data,
    input  logic               mem_ack,     // one cycle, data valid with it
    output logic               fill_sel0,   // slot 0 granted
    output logic               fill_sel1,   // slot 1 granted
    output logic               fill_ok,
    output rom_bus_pkg::word_t fill_data,
    output logic [AW-3:0]      mem_addr,    // word address
    output logic               mem_rd       // held until ack
);

    rom_arb_pkg::arb_state_t state;
    rom_arb_pkg::arb_state_t state_nx;
    rom_arb_pkg::slot_id_t   grant;       // owner of the current read
    rom_arb_pkg::slot_id_t   pick;        // winner if we issue now
    logic [AW-3:0]           pick_word;
    logic                    any_req;
    logic                    busy;
    logic                    issue;

    assign any_req = req0 || req1;
    assign busy    = (state == rom_arb_pkg::ARB_WAIT);
    assign issue   = (state == rom_arb_pkg::ARB_IDLE) && any_req;

    // fixed priority, slot 0 first
    always_comb begin
        if (req0) begin
            pick      = rom_arb_pkg::SLOT_0;
            pick_word = addr_req0[AW-1:2];
        end else begin
            pick      = rom_arb_pkg::SLOT_1;
            pick_word = addr_req1[AW-1:2];
        end
    end

    // next state
    always_comb begin
        state_nx = state;
        case (state)
            rom_arb_pkg::ARB_IDLE: begin
                if (any_req) begin
                    state_nx = rom_arb_pkg::ARB_WAIT;
                end
            end
            rom_arb_pkg::ARB_WAIT: begin
                if (mem_ack) begin
                    state_nx = rom_arb_pkg::ARB_IDLE;    // free on the ack edge
                end
            end
            default: state_nx = rom_arb_pkg::ARB_IDLE;
        endcase
    end

    // fsm, grant and read level
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= rom_arb_pkg::ARB_IDLE;
            grant  <= rom_arb_pkg::SLOT_0;
            mem_rd <= 1'b0;
        end else begin
            state <= state_nx;
            if (issue) begin
                grant  <= pick;
                mem_rd <= 1'b1;
            end else if (busy && mem_ack) begin
                mem_rd <= 1'b0;
            end
        end
    end

    // word address only changes when a new read starts,
    // so it stays put for the whole mem_rd window
    always_ff @(posedge clk) begin
        if (issue) begin
            mem_addr <= pick_word;
        end
    end

    // steer the returned word, each slot qualifies it with its own sel
    assign fill_sel0 = busy && (grant == rom_arb_pkg::SLOT_0);
    assign fill_sel1 = busy && (grant == rom_arb_pkg::SLOT_1);
    assign fill_ok   = busy && mem_ack;    // stray acks are ignored
    assign fill_data = mem_data;

endmodule

// ==== hw/rom_fetch_top.sv ====
`timescale 1ns/10ps

module rom_fetch_top #(
    parameter int AW = 20    // cpu byte address width
) (
    input  logic               clk,
    input  logic               rst,
    // 8-bit cpu
    input  logic [AW-1:0]      addr0,
    input  logic               addr0_ok,
    output rom_bus_pkg::byte_t dout0,
    output logic               data0_ok,
    // 16-bit cpu
    input  logic [AW-1:0]      addr1,
    input  logic               addr1_ok,
    output rom_bus_pkg::half_t dout1,
    output logic               data1_ok,
    // external rom
    output logic [AW-3:0]      mem_addr,
    output logic               mem_rd,
    input  rom_bus_pkg::word_t mem_data,
    input  logic               mem_ack
);

    logic               req0;
    logic               req1;
    logic [AW-1:0]      addr_req0;
    logic [AW-1:0]      addr_req1;
    logic               fill_sel0;
    logic               fill_sel1;
    logic               fill_ok;     // shared by both slots
    rom_bus_pkg::word_t fill_data;   // shared by both slots

    // slot 0, byte cpu with A0 swap
    rom_slot #(
        .AW        (AW),
        .DW        (8),
        .INVERT_A0 (1'b1)
    ) u_slot0 (
        .clk       (clk),
        .rst       (rst),
        .addr      (addr0),
        .addr_ok   (addr0_ok),
        .fill_data (fill_data),
        .fill_ok   (fill_ok),
        .fill_sel  (fill_sel0),
        .req       (req0),
        .addr_req  (addr_req0),
        .data_ok   (data0_ok),
        .dout      (dout0)
    );

    // slot 1, halfword cpu
    rom_slot #(
        .AW        (AW),
        .DW        (16),
        .INVERT_A0 (1'b0)
    ) u_slot1 (
        .clk       (clk),
        .rst       (rst),
        .addr      (addr1),
        .addr_ok   (addr1_ok),
        .fill_data (fill_data),
        .fill_ok   (fill_ok),
        .fill_sel  (fill_sel1),
        .req       (req1),
        .addr_req  (addr_req1),
        .data_ok   (data1_ok),
        .dout      (dout1)
    );

    rom_arbiter #(
        .AW        (AW)
    ) u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .req0      (req0),
        .req1      (req1),
        .addr_req0 (addr_req0),
        .addr_req1 (addr_req1),
        .mem_data  (mem_data),
        .mem_ack   (mem_ack),
        .fill_sel0 (fill_sel0),
        .fill_sel1 (fill_sel1),
        .fill_ok   (fill_ok),
        .fill_data (fill_data),
        .mem_addr  (mem_addr),
        .mem_rd    (mem_rd)
    );

endmodule

// ==== verification/rom_fetch_assertions.sv ====
`timescale 1ns/10ps

module rom_fetch_assertions #(
    parameter int AW = 20
) (
    input logic                    clk,
    input logic                    rst,
    input logic                    fill_sel0,
    input logic                    fill_sel1,
    input logic [AW-3:0]           mem_addr,
    input logic                    mem_rd,
    input rom_arb_pkg::arb_state_t state
);

    // only one slot may own the port
    grant_onehot: assert property (@(posedge clk) disable iff (rst)
        !(fill_sel0 && fill_sel1))
        else $error("both slots granted at once");

    // address held for the whole read
    addr_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_rd && $past(mem_rd)) |-> $stable(mem_addr))
        else $error("mem_addr moved while mem_rd was high");

    // no read level without an outstanding transaction
    idle_no_rd: assert property (@(posedge clk) disable iff (rst)
        (state == rom_arb_pkg::ARB_IDLE) |-> !mem_rd)
        else $error("mem_rd high in idle state");

endmodule

// ==== verification/rom_fetch_tb.sv ====
`timescale 1ns/10ps

module rom_fetch_tb;

    localparam int AW = 20;
    localparam int TMO = 200;    // cycles per wait

    logic               clk = 1'b0;
    logic               rst;
    logic [AW-1:0]      addr0;
    logic               addr0_ok;
    logic [AW-1:0]      addr1;
    logic               addr1_ok;
    rom_bus_pkg::word_t mem_data;
    logic               mem_ack;
    rom_bus_pkg::byte_t dout0;
    logic               data0_ok;
    rom_bus_pkg::half_t dout1;
    logic               data1_ok;
    logic [AW-3:0]      mem_addr;
    logic               mem_rd;

    logic [31:0]        rng = 32'd18310;
    int                 reads = 0;       // mem_rd rising edges
    int                 misses = 0;      // model misses
    int                 wait_left = 0;
    bit                 serving = 1'b0;
    logic [AW-3:0]      issued[$];       // word addresses in issue order
    logic [AW-3:0]      m_tag[2][2];     // cache model per slot
    bit                 m_init[2];
    bit                 m_victim[2];

    rom_fetch_top #(.AW(AW)) DUT (.*);

    bind rom_arbiter rom_fetch_assertions #(.AW(AW)) u_assert (
        .clk(clk), .rst(rst), .fill_sel0(fill_sel0), .fill_sel1(fill_sel1),
        .mem_addr(mem_addr), .mem_rd(mem_rd), .state(state)
    );

    always #4 clk = ~clk;    // 8 ns

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // rom content is a hash of the word address
    function automatic rom_bus_pkg::word_t rom_word(input logic [AW-3:0] w);
        logic [31:0] x;
        x = {{(34-AW){1'b0}}, w};
        return (x * 32'h9E37_79B1) ^ (x << 11) ^ 32'hC3A5_0F1E;
    endfunction

    function automatic rom_bus_pkg::byte_t exp_byte(input logic [AW-1:0] a);
        rom_bus_pkg::word_t w;
        logic [1:0]         lane;
        w    = rom_word(a[AW-1:2]);
        lane = {a[1], ~a[0]};    // A0 inverted on the byte cpu
        return w[lane*8 +: 8];
    endfunction

    function automatic rom_bus_pkg::half_t exp_half(input logic [AW-1:0] a);
        rom_bus_pkg::word_t w;
        w = rom_word(a[AW-1:2]);
        return a[1] ? w[31:16] : w[15:0];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_byte(input string name, input rom_bus_pkg::byte_t got,
                              input rom_bus_pkg::byte_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_half(input string name, input rom_bus_pkg::half_t got,
                              input rom_bus_pkg::half_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_word_addr(input string name, input logic [AW-3:0] got,
                                   input logic [AW-3:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    // first fill writes both entries and later fills alternate
    task automatic model_access(input int s, input logic [AW-3:0] w);
        if (!m_init[s] && (m_tag[s][0] == w || m_tag[s][1] == w)) begin
            return;
        end
        misses++;
        if (m_init[s]) begin
            m_tag[s][0] = w;
            m_tag[s][1] = w;
            m_init[s]   = 1'b0;
        end else begin
            m_tag[s][m_victim[s]] = w;
            m_victim[s] = ~m_victim[s];
        end
    endtask

    task automatic read_byte(input logic [AW-1:0] a);
        int t;
        model_access(0, a[AW-1:2]);
        @(posedge clk);
        #1;
        addr0    = a;
        addr0_ok = 1'b1;
        t = 0;
        do begin
            @(posedge clk);
            #1;
            t++;
        end while (!data0_ok && t < TMO);
        if (!data0_ok) abort_run("slot 0 never returned data");
        addr0_ok = 1'b0;    // addr stays so the compare sees it
    endtask

    task automatic read_half(input logic [AW-1:0] a);
        int t;
        model_access(1, a[AW-1:2]);
        @(posedge clk);
        #1;
        addr1    = a;
        addr1_ok = 1'b1;
        t = 0;
        do begin
            @(posedge clk);
            #1;
            t++;
        end while (!data1_ok && t < TMO);
        if (!data1_ok) abort_run("slot 1 never returned data");
        addr1_ok = 1'b0;
    endtask

    function automatic logic [AW-3:0] pool_word(input logic [AW-3:0] base);
        logic [31:0] r;
        r = next_rand();
        return base + {{(AW-5){1'b0}}, r[2:0]};    // 8 word window gives lots of hits
    endfunction

    // memory model with random 1..6 cycle latency
    always @(posedge clk) begin
        #1;
        if (rst) begin
            mem_ack  = 1'b0;
            mem_data = '0;
            serving  = 1'b0;
        end else if (mem_ack) begin
            mem_ack = 1'b0;
        end else if (mem_rd) begin
            if (!serving) begin
                serving   = 1'b1;
                wait_left = 1 + int'(next_rand() % 32'd6);
                reads++;
                issued.push_back(mem_addr);
            end
            wait_left--;
            if (wait_left == 0) begin
                mem_ack  = 1'b1;
                mem_data = rom_word(mem_addr);
                serving  = 1'b0;
            end
        end
    end

    // compare at every strobe in mid cycle
    always @(negedge clk) begin
        if (!rst && data0_ok) check_byte("dout0", dout0, exp_byte(addr0));
        if (!rst && data1_ok) check_half("dout1", dout1, exp_half(addr1));
    end

    initial begin
        int n;
        logic [AW-3:0] w;
        rst      = 1'b1;
        addr0    = '0;
        addr0_ok = 1'b0;
        addr1    = '0;
        addr1_ok = 1'b0;
        mem_ack  = 1'b0;
        mem_data = '0;
        m_init   = '{1'b1, 1'b1};
        m_victim = '{1'b0, 1'b0};
        repeat (3) begin
            @(posedge clk);
            #1;
            if (mem_rd || data0_ok || data1_ok) abort_run("outputs active in reset");
        end
        rst = 1'b0;
        @(posedge clk);
        #1;
        if (mem_rd || data0_ok || data1_ok) abort_run("outputs active after reset");

        // first access after reset must fetch
        read_byte({18'h00010, 2'd1});
        check_count("mem_rd count", reads, 1);

        // byte lanes on slot 0
        repeat (3) begin
            w = pool_word(18'h03000);
            for (int off = 0; off < 4; off++) read_byte({w, 2'(off)});
        end
        check_count("mem_rd count", reads, misses);

        // halves on slot 1
        repeat (3) begin
            w = pool_word(18'h03000);
            read_half({w, 2'd0});
            read_half({w, 2'd2});
        end
        check_count("mem_rd count", reads, misses);

        // hits then replacement
        read_half({18'h00100, 2'd0});
        read_half({18'h00101, 2'd2});
        n = reads;
        read_half({18'h00100, 2'd2});
        read_half({18'h00101, 2'd0});
        read_half({18'h00100, 2'd0});
        check_count("mem_rd count on hits", reads, n);
        read_half({18'h00102, 2'd0});
        read_half({18'h00100, 2'd0});
        read_half({18'h00101, 2'd2});
        read_half({18'h00102, 2'd2});
        check_count("mem_rd count", reads, misses);

        // both slots miss in the same cycle
        n = reads;
        fork
            read_byte({18'h00200, 2'd3});
            read_half({18'h00300, 2'd2});
        join
        check_word_addr("mem_addr", issued[n], 18'h00200);
        check_count("mem_rd count", reads, misses);

        // long random run
        repeat (300) begin
            fork
                read_byte({pool_word(18'h05000), 2'(next_rand())});
                read_half({pool_word(18'h05004), 2'(next_rand())});
            join
        end
        check_count("mem_rd count", reads, misses);

        repeat (4) @(posedge clk);
        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== rom_fetch_top.f ====
hw/rom_bus_pkg.sv
hw/rom_arb_pkg.sv
hw/rom_slot.sv
hw/rom_arbiter.sv
hw/rom_fetch_top.sv
verification/rom_fetch_assertions.sv
verification/rom_fetch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rom fetch testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module rom_fetch_tb \
    -f rom_fetch_top.f -o rom_fetch_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/rom_fetch_sim > sim.log 2>&1 || echo "simulator returned an error" >> sim.log
cat sim.log
grep -q "Test failures found" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "RESULT: FAIL"; exit 1; }
echo "RESULT: PASS"
exit 0
